/* Makefile */
TOP = tb_memory_subsystem

all: run

obj_dir/V$(TOP): all.f *.sv *.svh
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* all.f */
+incdir+.
mem_cmd_pkg.sv
mem_bus_pkg.sv
request_slot.sv
memory_interface.sv
word_memory.sv
memory_subsystem.sv
memory_subsystem_properties.sv
tb_memory_subsystem.sv

/* mem_bus_pkg.sv */
`include "mem_params.svh"

package mem_bus_pkg;

	typedef logic [`MEM_DATA_W-1:0] word_t;
	typedef logic [`MEM_ADDR_W-1:0] addr_t;

	// one bit per data bit, set bits take the new data
	typedef logic [`MEM_DATA_W-1:0] mask_t;

	// instruction fetch needs only the address
	typedef struct packed {
		addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		mem_cmd_pkg::mem_cmd_t cmd;
		addr_t                 addr;
		word_t                 wdata;
		mask_t                 wmask;
	} data_req_t;

endpackage

/* mem_cmd_pkg.sv */
package mem_cmd_pkg;

	// data port command
	typedef enum logic [1:0] {
		cmd_nop   = 2'd0,
		cmd_read  = 2'd1,
		cmd_write = 2'd2
	} mem_cmd_t;

	// arbiter sequencing
	typedef enum logic [1:0] {
		wait_cmd       = 2'd0,
		wait_mem_ready = 2'd1,
		wait_mem_read  = 2'd2,
		finish         = 2'd3
	} arb_state_t;

endpackage

/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// depth in words, indexed from address bit 2 upward
`define MEM_WORDS 1024

// cycles from an accepted command to the read data strobe, at least 2
`define MEM_READ_LATENCY 2

`endif

/* memory_interface.sv */
`timescale 1ns/1ps

module memory_interface
	import mem_cmd_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,

	input  logic       fetch_pending,
	input  fetch_req_t fetch_req,
	input  logic       data_pending,
	input  data_req_t  data_req,
	output logic       fetch_grant,
	output logic       data_grant,
	output logic       fetch_done,
	output logic       data_done,

	input  logic       fetch_start,
	output word_t      inst,
	output logic       inst_valid,
	input  logic       data_read_start,
	output word_t      rdata,
	output logic       rdata_valid,

	input  logic       mem_ready,
	output logic       mem_start,
	output logic       mem_write,
	output addr_t      mem_addr,
	output word_t      mem_wdata,
	output mask_t      mem_wmask,
	input  word_t      mem_rdata,
	input  logic       mem_rdata_valid
);

	arb_state_t state;
	// set while the fetch slot owns the bus
	logic sel_fetch;
	logic issue;
	logic data_is_read;
	logic read_back;

	assign issue        = (state == wait_mem_ready) && mem_ready;
	assign data_is_read = (data_req.cmd == cmd_read);
	assign read_back    = (state == wait_mem_read) && mem_rdata_valid;

	assign fetch_done = (state == finish) && sel_fetch;
	assign data_done  = (state == finish) && !sel_fetch;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= wait_cmd;
			sel_fetch <= 1'b0;
		end else begin
			case (state)
				wait_cmd: begin
					// fetch wins a tie
					if (fetch_pending || data_pending) begin
						sel_fetch <= fetch_pending;
						state     <= wait_mem_ready;
					end
				end
				wait_mem_ready: begin
					if (mem_ready) begin
						if (sel_fetch || data_is_read) begin
							state <= wait_mem_read;
						end else begin
							// writes need no answer
							state <= finish;
						end
					end
				end
				wait_mem_read: begin
					if (mem_rdata_valid) begin
						state <= finish;
					end
				end
				finish: begin
					// data request that arrived alongside the fetch
					if (sel_fetch && data_pending) begin
						sel_fetch <= 1'b0;
						state     <= wait_mem_ready;
					end else begin
						state <= wait_cmd;
					end
				end
				default: begin
					state <= wait_cmd;
				end
			endcase
		end
	end

	// single-cycle command strobe, grant goes out with it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_start   <= 1'b0;
			fetch_grant <= 1'b0;
			data_grant  <= 1'b0;
		end else begin
			mem_start   <= issue;
			fetch_grant <= issue && sel_fetch;
			data_grant  <= issue && !sel_fetch;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			mem_wdata <= data_req.wdata;
			mem_wmask <= data_req.wmask;
			if (sel_fetch) begin
				mem_addr  <= fetch_req.addr;
				mem_write <= 1'b0;
			end else begin
				mem_addr  <= data_req.addr;
				mem_write <= (data_req.cmd == cmd_write);
			end
		end
	end

	// valid levels hold until the same port asks again
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inst_valid  <= 1'b0;
			rdata_valid <= 1'b0;
		end else begin
			if (fetch_start) begin
				inst_valid <= 1'b0;
			end
			if (data_read_start) begin
				rdata_valid <= 1'b0;
			end
			if (read_back) begin
				if (sel_fetch) begin
					inst_valid <= 1'b1;
				end else begin
					rdata_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_back) begin
			if (sel_fetch) begin
				inst <= mem_rdata;
			end else begin
				rdata <= mem_rdata;
			end
		end
	end

endmodule

/* memory_subsystem.sv */
`timescale 1ns/1ps

module memory_subsystem
	import mem_cmd_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,

	input  logic     inst_start,
	input  addr_t    i_addr,
	output logic     inst_ready,
	output word_t    inst,
	output logic     inst_valid,

	input  mem_cmd_t d_cmd,
	output logic     d_cmd_ready,
	input  addr_t    d_addr,
	input  word_t    wdata,
	input  mask_t    wmask,
	output word_t    rdata,
	output logic     rdata_valid
);

	fetch_req_t fetch_in;
	fetch_req_t fetch_req;
	data_req_t  data_in;
	data_req_t  data_req;

	logic data_req_strobe;
	logic fetch_start;
	logic data_read_start;
	logic fetch_pending;
	logic data_pending;
	logic fetch_grant;
	logic data_grant;
	logic fetch_done;
	logic data_done;

	logic  mem_ready;
	logic  mem_start;
	logic  mem_write;
	addr_t mem_addr;
	word_t mem_wdata;
	mask_t mem_wmask;
	word_t mem_rdata;
	logic  mem_rdata_valid;

	assign fetch_in.addr = i_addr;
	assign data_in.cmd   = d_cmd;
	assign data_in.addr  = d_addr;
	assign data_in.wdata = wdata;
	assign data_in.wmask = wmask;

	// nop is no request at all
	assign data_req_strobe = (d_cmd != cmd_nop);
	assign fetch_start     = inst_start && inst_ready;
	assign data_read_start = (d_cmd == cmd_read) && d_cmd_ready;

	request_slot #(
		.payload_t(fetch_req_t)
	) u_fetch_slot (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (inst_start),
		.req_payload (fetch_in),
		.grant       (fetch_grant),
		.done        (fetch_done),
		.ready       (inst_ready),
		.pending     (fetch_pending),
		.payload     (fetch_req)
	);

	request_slot #(
		.payload_t(data_req_t)
	) u_data_slot (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (data_req_strobe),
		.req_payload (data_in),
		.grant       (data_grant),
		.done        (data_done),
		.ready       (d_cmd_ready),
		.pending     (data_pending),
		.payload     (data_req)
	);

	memory_interface u_arbiter (
		.clk             (clk),
		.arst_n          (arst_n),
		.fetch_pending   (fetch_pending),
		.fetch_req       (fetch_req),
		.data_pending    (data_pending),
		.data_req        (data_req),
		.fetch_grant     (fetch_grant),
		.data_grant      (data_grant),
		.fetch_done      (fetch_done),
		.data_done       (data_done),
		.fetch_start     (fetch_start),
		.inst            (inst),
		.inst_valid      (inst_valid),
		.data_read_start (data_read_start),
		.rdata           (rdata),
		.rdata_valid     (rdata_valid),
		.mem_ready       (mem_ready),
		.mem_start       (mem_start),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_wmask       (mem_wmask),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid)
	);

	word_memory u_memory (
		.clk         (clk),
		.arst_n      (arst_n),
		.start       (mem_start),
		.write       (mem_write),
		.addr        (mem_addr),
		.wdata       (mem_wdata),
		.wmask       (mem_wmask),
		.ready       (mem_ready),
		.rdata       (mem_rdata),
		.rdata_valid (mem_rdata_valid)
	);

endmodule

/* memory_subsystem_properties.sv */
`timescale 1ns/1ps

module memory_subsystem_properties (
	input logic clk,
	input logic arst_n,
	input logic fetch_pending,
	input logic data_pending,
	input logic mem_ready,
	input logic mem_start,
	input logic fetch_grant,
	input logic data_grant
);

	// memory takes a command only while free
	property start_when_ready;
		@(posedge clk) disable iff (!arst_n)
		mem_start |-> mem_ready;
	endproperty

	// bus goes to one waiting slot at a time
	property one_grant;
		@(posedge clk) disable iff (!arst_n)
		!(fetch_grant && data_grant)
			&& (!fetch_grant || fetch_pending)
			&& (!data_grant || data_pending);
	endproperty

	// granted command is taken by the memory
	property grant_taken;
		@(posedge clk) disable iff (!arst_n)
		(fetch_grant || data_grant) |=> !mem_ready;
	endproperty

	a_start_when_ready: assert property (start_when_ready)
		else $error("mem_start while the memory is busy");
	a_one_grant: assert property (one_grant)
		else $error("grant to both slots or to a slot with nothing pending");
	a_grant_taken: assert property (grant_taken)
		else $error("granted command not taken by the memory");

endmodule

bind memory_interface memory_subsystem_properties u_properties (
	.clk           (clk),
	.arst_n        (arst_n),
	.fetch_pending (fetch_pending),
	.data_pending  (data_pending),
	.mem_ready     (mem_ready),
	.mem_start     (mem_start),
	.fetch_grant   (fetch_grant),
	.data_grant    (data_grant)
);

/* memory_trace.txt */
// kind addr wdata wmask expected fetch_addr fetch_expected, all hex
// kind 1 fetch, 2 read, 3 write, 4 fetch with read, 5 fetch with write, 0 ends the trace
3 00000010 deadbeef ffffffff deadbeef 00000000 00000000
2 00000010 00000000 00000000 deadbeef 00000000 00000000
3 00000010 12345678 0000ffff dead5678 00000000 00000000
2 00000010 00000000 00000000 dead5678 00000000 00000000
3 00000020 a5a5a5a5 ff00ff00 a500a500 00000000 00000000
2 00000020 00000000 00000000 a500a500 00000000 00000000
3 00000100 00000013 ffffffff 00000013 00000000 00000000
3 00000104 00a00093 ffffffff 00a00093 00000000 00000000
1 00000100 00000000 00000000 00000013 00000000 00000000
1 00000104 00000000 00000000 00a00093 00000000 00000000
1 00000108 00000000 00000000 00000000 00000000 00000000
4 00000010 00000000 00000000 dead5678 00000100 00000013
5 00000030 cafef00d ffffffff cafef00d 00000104 00a00093
2 00000030 00000000 00000000 cafef00d 00000000 00000000
5 00000020 5a5a5a5a 0f0f0f0f aa0aaa0a 00000108 00000000
2 00000020 00000000 00000000 aa0aaa0a 00000000 00000000
4 00000104 00000000 00000000 00a00093 00000010 dead5678
3 000003fc 11111111 ffff0000 11110000 00000000 00000000
1 000003fc 00000000 00000000 11110000 00000000 00000000
2 000003fc 00000000 00000000 11110000 00000000 00000000
0 00000000 00000000 00000000 00000000 00000000 00000000

/* request_slot.sv */
`timescale 1ns/1ps

module request_slot #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     req,
	input  payload_t req_payload,
	input  logic     grant,
	input  logic     done,
	output logic     ready,
	output logic     pending,
	output payload_t payload
);

	logic capture;

	// a request only counts while the port is free
	assign capture = req && ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready   <= 1'b1;
			pending <= 1'b0;
		end else begin
			if (capture) begin
				ready   <= 1'b0;
				pending <= 1'b1;
			end else begin
				// bus taken, still busy until done
				if (grant) begin
					pending <= 1'b0;
				end
				if (done) begin
					ready <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			payload <= req_payload;
		end
	end

endmodule

/* tb_memory_subsystem.sv */
`timescale 1ns/1ps

`include "mem_params.svh"

module tb_memory_subsystem
	import mem_cmd_pkg::*;
	import mem_bus_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int TRACE_COLS  = 7;
	localparam int TRACE_LINES = 64;
	localparam int READY_LIMIT = 40;

	// trace kinds
	localparam int KIND_FETCH      = 1;
	localparam int KIND_READ       = 2;
	localparam int KIND_WRITE      = 3;
	localparam int KIND_DUAL_READ  = 4;
	localparam int KIND_DUAL_WRITE = 5;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     inst_start;
	addr_t    i_addr;
	logic     inst_ready;
	word_t    inst;
	logic     inst_valid;
	mem_cmd_t d_cmd;
	logic     d_cmd_ready;
	addr_t    d_addr;
	word_t    wdata;
	mask_t    wmask;
	word_t    rdata;
	logic     rdata_valid;

	logic [31:0] trace_mem [TRACE_LINES * TRACE_COLS];
	word_t       model [int];
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          checks = 0;
	int          op_count = 0;
	bit          trace_loaded = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	memory_subsystem u_memory_subsystem (
		.clk         (clk),
		.arst_n      (arst_n),
		.inst_start  (inst_start),
		.i_addr      (i_addr),
		.inst_ready  (inst_ready),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.d_cmd       (d_cmd),
		.d_cmd_ready (d_cmd_ready),
		.d_addr      (d_addr),
		.wdata       (wdata),
		.wmask       (wmask),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_level(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// reference memory, word index wraps at the memory depth
	function automatic word_t model_read(input addr_t addr);
		int idx;
		idx = int'((addr >> 2) % `MEM_WORDS);
		if (model.exists(idx)) begin
			return model[idx];
		end
		return '0;
	endfunction

	task automatic model_write(input addr_t addr, input word_t data, input mask_t mask);
		int idx;
		idx = int'((addr >> 2) % `MEM_WORDS);
		model[idx] = (model_read(addr) & ~mask) | (data & mask);
	endtask

	task automatic wait_ready(input bit need_fetch, input bit need_data, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		@(negedge clk);
		while (ok && ((need_fetch && !inst_ready) || (need_data && !d_cmd_ready))) begin
			if (cycles == READY_LIMIT) begin
				protocol_errors++;
				$display("port ready did not come back within %0d cycles", READY_LIMIT);
				ok = 1'b0;
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	// random idle gap, then a one-cycle request on one or both ports
	task automatic send_request(input bit do_fetch, input addr_t f_addr, input mem_cmd_t cmd,
			input addr_t addr, input word_t data, input mask_t mask);
		int gap;
		gap = int'($urandom % 32'd4);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		#2;
		inst_start = do_fetch;
		i_addr     = f_addr;
		d_cmd      = cmd;
		d_addr     = addr;
		wdata      = data;
		wmask      = mask;
		@(posedge clk);
		#2;
		inst_start = 1'b0;
		d_cmd      = cmd_nop;
	endtask

	task automatic run_port_read(input bit fetch_side, input addr_t addr, input word_t trace_exp);
		word_t expected;
		bit    ok;
		int    cycles;
		string port;
		port = fetch_side ? "fetch" : "read";
		expected = model_read(addr);
		compare_word({port, " trace entry"}, expected, trace_exp);
		wait_ready(fetch_side, !fetch_side, ok);
		if (ok) begin
			if (fetch_side) begin
				send_request(1'b1, addr, cmd_nop, '0, '0, '0);
			end else begin
				send_request(1'b0, '0, cmd_read, addr, '0, '0);
			end
			// old result drops once the new request is taken
			@(negedge clk);
			compare_level({port, " valid drop"}, 1'b0, fetch_side ? inst_valid : rdata_valid);
			cycles = 0;
			while (!(fetch_side ? inst_valid : rdata_valid) && cycles < READY_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (!(fetch_side ? inst_valid : rdata_valid)) begin
				protocol_errors++;
				$display("%s result never became valid", port);
			end else begin
				compare_word(port, expected, fetch_side ? inst : rdata);
				wait_ready(fetch_side, !fetch_side, ok);
				if (ok) begin
					compare_level({port, " valid hold"}, 1'b1, fetch_side ? inst_valid : rdata_valid);
					compare_word({port, " word hold"}, expected, fetch_side ? inst : rdata);
				end
			end
		end
	endtask

	task automatic run_write(input addr_t addr, input word_t data, input mask_t mask,
			input word_t trace_exp);
		bit ok;
		model_write(addr, data, mask);
		compare_word("write trace entry", model_read(addr), trace_exp);
		wait_ready(1'b0, 1'b1, ok);
		if (ok) begin
			send_request(1'b0, '0, cmd_write, addr, data, mask);
		end
	endtask

	task automatic run_dual(input bit with_write, input addr_t addr, input word_t data,
			input mask_t mask, input word_t trace_exp, input addr_t f_addr, input word_t f_trace_exp);
		word_t    f_expected;
		word_t    d_expected;
		mem_cmd_t cmd;
		bit       ok;
		bit       fetch_seen;
		bit       data_seen;
		bit       ready_bad;
		int       cycles;
		int       fetch_cycle;
		int       data_cycle;
		// fetch goes first, so it sees the word before the write
		f_expected = model_read(f_addr);
		if (with_write) begin
			model_write(addr, data, mask);
			cmd = cmd_write;
		end else begin
			cmd = cmd_read;
		end
		d_expected = model_read(addr);
		compare_word("dual fetch trace entry", f_expected, f_trace_exp);
		compare_word("dual data trace entry", d_expected, trace_exp);
		wait_ready(1'b1, 1'b1, ok);
		if (ok) begin
			send_request(1'b1, f_addr, cmd, addr, data, mask);
			fetch_seen  = 1'b0;
			data_seen   = 1'b0;
			ready_bad   = 1'b0;
			cycles      = 0;
			fetch_cycle = 0;
			data_cycle  = 0;
			while (!(fetch_seen && data_seen) && cycles < READY_LIMIT) begin
				@(negedge clk);
				cycles++;
				if (!ready_bad && ((inst_ready && !inst_valid) ||
						(d_cmd_ready && !(with_write ? inst_valid : rdata_valid)))) begin
					ready_bad = 1'b1;
					protocol_errors++;
					$display("a port was ready again before its own operation had finished");
				end
				if (inst_valid && !fetch_seen) begin
					fetch_seen  = 1'b1;
					fetch_cycle = cycles;
				end
				if (!data_seen && (with_write ? (d_cmd_ready && fetch_seen) : rdata_valid)) begin
					data_seen  = 1'b1;
					data_cycle = cycles;
				end
			end
			if (!(fetch_seen && data_seen)) begin
				protocol_errors++;
				$display("dual request did not complete within %0d cycles", READY_LIMIT);
			end else begin
				compare_word("dual fetch", f_expected, inst);
				if (!with_write) begin
					compare_level("dual fetch first", 1'b1, logic'(fetch_cycle <= data_cycle));
					compare_word("dual read", d_expected, rdata);
				end
			end
		end
	endtask

	initial begin
		int base;
		int kind;
		void'($urandom(32'h53a6a671));
		arst_n     = 1'b0;
		inst_start = 1'b0;
		i_addr     = '0;
		d_cmd      = cmd_nop;
		d_addr     = '0;
		wdata      = '0;
		wmask      = '0;
		for (int i = 0; i < TRACE_LINES * TRACE_COLS; i++) begin
			trace_mem[i] = '0;
		end
		$readmemh("memory_trace.txt", trace_mem);
		// kind 0 ends the trace
		while (op_count < TRACE_LINES && trace_mem[op_count * TRACE_COLS] != 32'd0) begin
			op_count++;
		end
		trace_loaded = 1'b1;

		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(negedge clk);
		compare_level("reset inst_ready", 1'b1, inst_ready);
		compare_level("reset d_cmd_ready", 1'b1, d_cmd_ready);
		compare_level("reset inst_valid", 1'b0, inst_valid);
		compare_level("reset rdata_valid", 1'b0, rdata_valid);

		for (int op = 0; op < op_count; op++) begin
			base = op * TRACE_COLS;
			kind = int'(trace_mem[base]);
			case (kind)
				KIND_FETCH: run_port_read(1'b1, trace_mem[base + 1], trace_mem[base + 4]);
				KIND_READ: run_port_read(1'b0, trace_mem[base + 1], trace_mem[base + 4]);
				KIND_WRITE: run_write(trace_mem[base + 1], trace_mem[base + 2], trace_mem[base + 3],
						trace_mem[base + 4]);
				KIND_DUAL_READ, KIND_DUAL_WRITE: run_dual(kind == KIND_DUAL_WRITE,
						trace_mem[base + 1], trace_mem[base + 2], trace_mem[base + 3],
						trace_mem[base + 4], trace_mem[base + 5], trace_mem[base + 6]);
				default: begin
					protocol_errors++;
					$display("unknown operation kind %0d on trace line %0d", kind, op);
				end
			endcase
		end

		$display("checks %0d, value errors %0d, protocol errors %0d",
				checks, value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog, 40 cycles per trace line plus reset
	initial begin
		longint limit_ns;
		wait (trace_loaded);
		limit_ns = longint'(op_count * 40 + 16) * CLK_PERIOD;
		#(limit_ns);
		$display("watchdog expired after %0d ns with the trace unfinished", limit_ns);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* word_memory.sv */
`timescale 1ns/1ps

`include "mem_params.svh"

module word_memory
	import mem_bus_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  start,
	input  logic  write,
	input  addr_t addr,
	input  word_t wdata,
	input  mask_t wmask,
	output logic  ready,
	output word_t rdata,
	output logic  rdata_valid
);

	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`MEM_READ_LATENCY + 1);

	word_t mem [`MEM_WORDS];

	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] rd_idx;
	logic [CNT_W-1:0] cnt;
	logic             accept;
	logic             reading;
	logic             wr_done;

	// word index, byte offset dropped
	assign idx    = addr[IDX_W+1:2];
	assign accept = start && ready;

	// contents start cleared
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready       <= 1'b1;
			reading     <= 1'b0;
			wr_done     <= 1'b0;
			rdata_valid <= 1'b0;
			cnt         <= '0;
		end else begin
			rdata_valid <= 1'b0;
			wr_done     <= accept && write;
			if (accept) begin
				ready <= 1'b0;
				if (!write) begin
					reading <= 1'b1;
					cnt     <= CNT_W'(`MEM_READ_LATENCY - 1);
				end
			end else if (reading) begin
				if (cnt == CNT_W'(1)) begin
					reading     <= 1'b0;
					rdata_valid <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end else if (rdata_valid || wr_done) begin
				// free again one cycle after the access ends
				ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			if (write) begin
				mem[idx] <= (mem[idx] & ~wmask) | (wdata & wmask);
			end else begin
				rd_idx <= idx;
			end
		end
		if (reading && cnt == CNT_W'(1)) begin
			rdata <= mem[rd_idx];
		end
	end

endmodule
